// File: verilog/dcache_pkg.sv
package dcache_pkg;

    // cache geometry
    localparam int unsigned words_per_line = 16;
    localparam int unsigned num_sets       = 4;
    localparam int unsigned num_ways       = 4;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  strb_t;
    typedef logic [23:0] tag_t;      // addr[31:8]
    typedef logic [1:0]  set_idx_t;  // addr[7:6]
    typedef logic [1:0]  way_idx_t;
    typedef logic [3:0]  word_idx_t; // addr[5:2]

    typedef struct packed {
        logic  valid;
        logic  write;
        addr_t addr;
        strb_t wstrb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  ack;   // one cycle pulse
        word_t rdata;
    } cpu_resp_t;

    // shared by AR and AW
    typedef struct packed {
        logic  valid;
        addr_t addr;
    } axi_addr_t;

    // shared by R and W
    typedef struct packed {
        logic  valid;
        word_t data;
        logic  last;
    } axi_data_t;

    function automatic tag_t addr_tag(addr_t a);
        return a[31:8];
    endfunction

    function automatic set_idx_t addr_set(addr_t a);
        return a[7:6];
    endfunction

    function automatic word_idx_t addr_word(addr_t a);
        return a[5:2];
    endfunction

    // line aligned byte address of a tag in a set
    function automatic addr_t line_addr(tag_t t, set_idx_t s);
        return {t, s, 6'b00_0000};
    endfunction

endpackage

// File: verilog/dcache_tag_array.sv
`timescale 1ns/1ps

module dcache_tag_array (
    input  logic                 clk,
    input  logic                 arst_n,
    input  dcache_pkg::set_idx_t lk_set,
    input  dcache_pkg::tag_t     lk_tag,
    input  logic                 set_dirty,
    input  logic                 install,
    input  dcache_pkg::way_idx_t upd_way,
    output logic                 hit,
    output dcache_pkg::way_idx_t hit_way,
    output dcache_pkg::way_idx_t victim_way,
    output logic                 victim_valid,
    output logic                 victim_dirty,
    output dcache_pkg::tag_t     victim_tag
);

    dcache_pkg::tag_t     tag_q   [dcache_pkg::num_sets][dcache_pkg::num_ways];
    logic [dcache_pkg::num_ways-1:0] valid_q [dcache_pkg::num_sets];
    logic [dcache_pkg::num_ways-1:0] dirty_q [dcache_pkg::num_sets];
    dcache_pkg::way_idx_t fifo_q  [dcache_pkg::num_sets];   // next way to replace

    always_ff @(posedge clk) begin
        if (install) tag_q[lk_set][upd_way] <= lk_tag;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < dcache_pkg::num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                fifo_q[s]  <= '0;
            end
        end else if (install) begin
            valid_q[lk_set][upd_way] <= 1'b1;
            dirty_q[lk_set][upd_way] <= 1'b0;
            fifo_q[lk_set]           <= fifo_q[lk_set] + 2'd1;
        end else if (set_dirty) begin
            dirty_q[lk_set][upd_way] <= 1'b1;
        end
    end

    // parallel compare over the ways of the looked up set
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::num_ways; w++) begin
            if (valid_q[lk_set][w] && tag_q[lk_set][w] == lk_tag) begin
                hit     = 1'b1;
                hit_way = dcache_pkg::way_idx_t'(w);
            end
        end
    end

    assign victim_way   = fifo_q[lk_set];
    assign victim_valid = valid_q[lk_set][victim_way];
    assign victim_dirty = dirty_q[lk_set][victim_way];
    assign victim_tag   = tag_q[lk_set][victim_way];

endmodule

// File: verilog/dcache_data_array.sv
`timescale 1ns/1ps

module dcache_data_array (
    input  logic                  clk,
    input  dcache_pkg::set_idx_t  set,
    input  dcache_pkg::way_idx_t  way,
    input  dcache_pkg::word_idx_t word,
    input  logic                  we,
    input  dcache_pkg::strb_t     strb,
    input  dcache_pkg::word_t     wdata,
    output dcache_pkg::word_t     rdata
);

    dcache_pkg::word_t mem [dcache_pkg::num_sets]
                           [dcache_pkg::num_ways]
                           [dcache_pkg::words_per_line];

    // byte merge of write data into the stored word
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) mem[set][way][word][b*8 +: 8] <= wdata[b*8 +: 8];
            end
        end
    end

    assign rdata = mem[set][way][word];  // async read

endmodule

// File: verilog/axi_burst_master.sv
`timescale 1ns/1ps

module axi_burst_master (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  wb_start,
    input  logic                  fill_start,
    input  dcache_pkg::addr_t     burst_addr,
    input  dcache_pkg::word_t     wb_data,
    input  logic                  m_arready,
    input  logic                  m_awready,
    input  logic                  m_wready,
    input  dcache_pkg::axi_data_t m_r,
    output logic                  wb_done,
    output logic                  fill_done,
    output dcache_pkg::word_idx_t beat_idx,
    output logic                  fill_we,
    output dcache_pkg::word_t     fill_data,
    output dcache_pkg::axi_addr_t m_ar,
    output dcache_pkg::axi_addr_t m_aw,
    output dcache_pkg::axi_data_t m_w
);

    typedef enum logic [2:0] {
        bm_idle,
        bm_ar,
        bm_r,
        bm_aw,
        bm_w
    } bm_state_t;

    bm_state_t             state_q;
    dcache_pkg::addr_t     addr_q;
    dcache_pkg::word_idx_t beat_q;
    logic                  last_beat;

    assign last_beat = (beat_q == dcache_pkg::word_idx_t'(dcache_pkg::words_per_line - 1));

    // line address is only captured on a start
    always_ff @(posedge clk) begin
        if (wb_start || fill_start) addr_q <= burst_addr;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= bm_idle;
            beat_q    <= '0;
            wb_done   <= 1'b0;
            fill_done <= 1'b0;
        end else begin
            wb_done   <= 1'b0;
            fill_done <= 1'b0;
            case (state_q)
                bm_idle: begin
                    beat_q <= '0;
                    if (wb_start)        state_q <= bm_aw;
                    else if (fill_start) state_q <= bm_ar;
                end
                bm_ar: if (m_arready) state_q <= bm_r;
                bm_aw: if (m_awready) state_q <= bm_w;
                bm_r: begin
                    if (m_r.valid) begin
                        beat_q <= beat_q + 4'd1;
                        if (m_r.last) begin
                            fill_done <= 1'b1;
                            state_q   <= bm_idle;
                        end
                    end
                end
                bm_w: begin
                    if (m_wready) begin
                        beat_q <= beat_q + 4'd1;
                        if (last_beat) begin
                            wb_done <= 1'b1;
                            state_q <= bm_idle;
                        end
                    end
                end
                default: state_q <= bm_idle;
            endcase
        end
    end

    assign m_ar.valid = (state_q == bm_ar);
    assign m_ar.addr  = addr_q;
    assign m_aw.valid = (state_q == bm_aw);
    assign m_aw.addr  = addr_q;

    // beat_q only moves on a handshake, so W data stays put under stall
    assign m_w.valid = (state_q == bm_w);
    assign m_w.data  = wb_data;
    assign m_w.last  = (state_q == bm_w) && last_beat;

    assign beat_idx  = beat_q;
    assign fill_we   = (state_q == bm_r) && m_r.valid;
    assign fill_data = m_r.data;

endmodule

// File: verilog/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl (
    input  logic                  clk,
    input  logic                  arst_n,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_resp_t cpu_resp,
    // tag array side
    output dcache_pkg::set_idx_t  lk_set,
    output dcache_pkg::tag_t      lk_tag,
    input  logic                  hit,
    input  dcache_pkg::way_idx_t  hit_way,
    input  dcache_pkg::way_idx_t  victim_way,
    input  logic                  victim_valid,
    input  logic                  victim_dirty,
    input  dcache_pkg::tag_t      victim_tag,
    output logic                  set_dirty,
    output logic                  install,
    output dcache_pkg::way_idx_t  upd_way,
    // data array side
    output dcache_pkg::way_idx_t  arr_way,
    output dcache_pkg::word_idx_t arr_word,
    output logic                  arr_we,
    output dcache_pkg::strb_t     arr_strb,
    output dcache_pkg::word_t     arr_wdata,
    input  dcache_pkg::word_t     rd_word,
    // burst engine side
    output logic                  wb_start,
    output logic                  fill_start,
    output dcache_pkg::addr_t     burst_addr,
    input  logic                  wb_done,
    input  logic                  fill_done,
    input  logic                  fill_we,
    input  dcache_pkg::word_idx_t beat_idx,
    input  dcache_pkg::word_t     fill_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_wb,
        st_fill
    } state_t;

    state_t               state_q;
    state_t               state_d;
    dcache_pkg::cpu_req_t req_q;
    logic                 in_lookup;

    assign in_lookup = (state_q == st_lookup);

    // request is held until ack, so one capture on accept is enough
    always_ff @(posedge clk) begin
        if (state_q == st_idle && cpu_req.valid) begin
            req_q <= cpu_req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign lk_set = dcache_pkg::addr_set(req_q.addr);
    assign lk_tag = dcache_pkg::addr_tag(req_q.addr);

    always_comb begin
        state_d    = state_q;
        wb_start   = 1'b0;
        fill_start = 1'b0;
        install    = 1'b0;
        case (state_q)
            st_idle: begin
                if (cpu_req.valid) state_d = st_lookup;
            end
            st_lookup: begin
                if (hit) begin
                    state_d = st_idle;
                end else if (victim_valid && victim_dirty) begin
                    wb_start = 1'b1;
                    state_d  = st_wb;
                end else begin
                    fill_start = 1'b1;   // clean or empty victim is dropped
                    state_d    = st_fill;
                end
            end
            st_wb: begin
                if (wb_done) begin
                    fill_start = 1'b1;
                    state_d    = st_fill;
                end
            end
            st_fill: begin
                if (fill_done) begin
                    install = 1'b1;
                    state_d = st_lookup;  // retried lookup now hits
                end
            end
            default: state_d = st_idle;
        endcase
    end

    assign burst_addr = wb_start ? dcache_pkg::line_addr(victim_tag, lk_set)
                                 : dcache_pkg::line_addr(lk_tag, lk_set);

    // data array index: processor word on lookup, burst beat otherwise
    always_comb begin
        arr_way   = victim_way;
        arr_word  = beat_idx;
        arr_we    = 1'b0;
        arr_strb  = '1;
        arr_wdata = fill_data;
        if (in_lookup) begin
            arr_way   = hit_way;
            arr_word  = dcache_pkg::addr_word(req_q.addr);
            arr_we    = hit & req_q.write;
            arr_strb  = req_q.wstrb;
            arr_wdata = req_q.wdata;
        end else if (state_q == st_fill) begin
            arr_we = fill_we;
        end
    end

    assign set_dirty = in_lookup & hit & req_q.write;
    assign upd_way   = install ? victim_way : hit_way;

    assign cpu_resp.ack   = in_lookup & hit;
    assign cpu_resp.rdata = rd_word;

endmodule

// File: verilog/dcache_top.sv
`timescale 1ns/1ps

module dcache_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  dcache_pkg::cpu_req_t  cpu_req,
    output dcache_pkg::cpu_resp_t cpu_resp,
    output dcache_pkg::axi_addr_t m_ar,
    input  logic                  m_arready,
    input  dcache_pkg::axi_data_t m_r,
    output dcache_pkg::axi_addr_t m_aw,
    input  logic                  m_awready,
    output dcache_pkg::axi_data_t m_w,
    input  logic                  m_wready
);

    dcache_pkg::set_idx_t  lk_set;
    dcache_pkg::tag_t      lk_tag;
    logic                  hit;
    dcache_pkg::way_idx_t  hit_way;
    dcache_pkg::way_idx_t  victim_way;
    logic                  victim_valid;
    logic                  victim_dirty;
    dcache_pkg::tag_t      victim_tag;
    logic                  set_dirty;
    logic                  install;
    dcache_pkg::way_idx_t  upd_way;

    dcache_pkg::way_idx_t  arr_way;
    dcache_pkg::word_idx_t arr_word;
    logic                  arr_we;
    dcache_pkg::strb_t     arr_strb;
    dcache_pkg::word_t     arr_wdata;
    dcache_pkg::word_t     rd_word;

    logic                  wb_start;
    logic                  fill_start;
    dcache_pkg::addr_t     burst_addr;
    logic                  wb_done;
    logic                  fill_done;
    logic                  fill_we;
    dcache_pkg::word_idx_t beat_idx;
    dcache_pkg::word_t     fill_data;

    dcache_ctrl u_ctrl (
        .clk          (clk),
        .arst_n       (arst_n),
        .cpu_req      (cpu_req),
        .cpu_resp     (cpu_resp),
        .lk_set       (lk_set),
        .lk_tag       (lk_tag),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .set_dirty    (set_dirty),
        .install      (install),
        .upd_way      (upd_way),
        .arr_way      (arr_way),
        .arr_word     (arr_word),
        .arr_we       (arr_we),
        .arr_strb     (arr_strb),
        .arr_wdata    (arr_wdata),
        .rd_word      (rd_word),
        .wb_start     (wb_start),
        .fill_start   (fill_start),
        .burst_addr   (burst_addr),
        .wb_done      (wb_done),
        .fill_done    (fill_done),
        .fill_we      (fill_we),
        .beat_idx     (beat_idx),
        .fill_data    (fill_data)
    );

    dcache_tag_array u_tags (
        .clk          (clk),
        .arst_n       (arst_n),
        .lk_set       (lk_set),
        .lk_tag       (lk_tag),
        .set_dirty    (set_dirty),
        .install      (install),
        .upd_way      (upd_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_valid (victim_valid),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    dcache_data_array u_data (
        .clk   (clk),
        .set   (lk_set),
        .way   (arr_way),
        .word  (arr_word),
        .we    (arr_we),
        .strb  (arr_strb),
        .wdata (arr_wdata),
        .rdata (rd_word)
    );

    axi_burst_master u_burst (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb_start   (wb_start),
        .fill_start (fill_start),
        .burst_addr (burst_addr),
        .wb_data    (rd_word),     // victim word selected by beat_idx
        .m_arready  (m_arready),
        .m_awready  (m_awready),
        .m_wready   (m_wready),
        .m_r        (m_r),
        .wb_done    (wb_done),
        .fill_done  (fill_done),
        .beat_idx   (beat_idx),
        .fill_we    (fill_we),
        .fill_data  (fill_data),
        .m_ar       (m_ar),
        .m_aw       (m_aw),
        .m_w        (m_w)
    );

endmodule

// File: tests/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model (
    input  logic                  clk,
    input  dcache_pkg::axi_addr_t m_ar,
    output logic                  m_arready,
    output dcache_pkg::axi_data_t m_r,
    input  dcache_pkg::axi_addr_t m_aw,
    output logic                  m_awready,
    input  dcache_pkg::axi_data_t m_w,
    output logic                  m_wready,
    output int                    ar_count,
    output int                    aw_count,
    output int                    w_count,
    output dcache_pkg::addr_t     last_ar_addr,
    output dcache_pkg::addr_t     last_aw_addr
);

    dcache_pkg::word_t mem [dcache_pkg::addr_t];  // only written words are stored

    integer            seed;
    logic              rd_active;
    dcache_pkg::addr_t rd_addr;
    int                rd_beat;
    dcache_pkg::addr_t wr_addr;
    int                wr_beat;

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t a);
        if (mem.exists(a)) return mem[a];
        return a ^ 32'hc0de_0000;
    endfunction

    initial begin
        seed         = 32'h5b31a14d;
        m_arready    = 1'b0;
        m_awready    = 1'b0;
        m_wready     = 1'b0;
        m_r          = '0;
        ar_count     = 0;
        aw_count     = 0;
        w_count      = 0;
        last_ar_addr = '0;
        last_aw_addr = '0;
        rd_active    = 1'b0;
        rd_addr      = '0;
        rd_beat      = 0;
        wr_addr      = '0;
        wr_beat      = 0;
    end

    always @(posedge clk) begin
        // handshakes of the closing cycle
        if (m_r.valid) begin
            rd_beat = rd_beat + 1;
            if (m_r.last) rd_active = 1'b0;
        end
        if (m_ar.valid && m_arready) begin
            rd_active    = 1'b1;
            rd_addr      = m_ar.addr;
            rd_beat      = 0;
            ar_count     = ar_count + 1;
            last_ar_addr = m_ar.addr;
        end
        if (m_aw.valid && m_awready) begin
            wr_addr      = m_aw.addr;
            wr_beat      = 0;
            aw_count     = aw_count + 1;
            last_aw_addr = m_aw.addr;
        end
        if (m_w.valid && m_wready) begin
            mem[wr_addr + dcache_pkg::addr_t'(4 * wr_beat)] = m_w.data;
            wr_beat = wr_beat + 1;
            w_count = w_count + 1;
        end
        #1;
        m_arready = ($random(seed) & 3) != 0;   // high about 3 cycles in 4
        m_awready = ($random(seed) & 3) != 0;
        m_wready  = ($random(seed) & 3) != 0;
        if (rd_active && (($random(seed) & 3) != 0)) begin
            m_r.valid = 1'b1;
            m_r.data  = read_word(rd_addr + dcache_pkg::addr_t'(4 * rd_beat));
            m_r.last  = (rd_beat == 15);
        end else begin
            m_r = '0;
        end
    end

endmodule

// File: tests/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker (
    input logic                  clk,
    input logic                  arst_n,
    input dcache_pkg::cpu_resp_t cpu_resp,
    input dcache_pkg::axi_addr_t m_ar,
    input logic                  m_arready,
    input dcache_pkg::axi_addr_t m_aw,
    input logic                  m_awready,
    input dcache_pkg::axi_data_t m_w,
    input logic                  m_wready
);

    logic [3:0] w_beats;   // W handshakes seen in the current burst

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_beats <= '0;
        end else if (m_w.valid && m_wready) begin
            w_beats <= m_w.last ? 4'd0 : w_beats + 4'd1;
        end
    end

    ar_hold: assert property (@(posedge clk) disable iff (!arst_n)
        m_ar.valid && !m_arready |=> m_ar.valid && $stable(m_ar.addr))
        else $error("AR dropped or changed while stalled");

    aw_hold: assert property (@(posedge clk) disable iff (!arst_n)
        m_aw.valid && !m_awready |=> m_aw.valid && $stable(m_aw.addr))
        else $error("AW dropped or changed while stalled");

    w_hold: assert property (@(posedge clk) disable iff (!arst_n)
        m_w.valid && !m_wready |=> m_w.valid && $stable(m_w.data) && $stable(m_w.last))
        else $error("W beat dropped or changed while stalled");

    ack_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        cpu_resp.ack |=> !cpu_resp.ack)
        else $error("ack held for two cycles");

    wlast_beat: assert property (@(posedge clk) disable iff (!arst_n)
        m_w.valid |-> (m_w.last == (w_beats == 4'd15)))
        else $error("W last not on beat 16");

endmodule

bind dcache_top dcache_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .cpu_resp  (cpu_resp),
    .m_ar      (m_ar),
    .m_arready (m_arready),
    .m_aw      (m_aw),
    .m_awready (m_awready),
    .m_w       (m_w),
    .m_wready  (m_wready)
);

// File: tests/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    typedef struct packed {
        logic              write;
        dcache_pkg::addr_t addr;
        dcache_pkg::strb_t wstrb;
        dcache_pkg::word_t wdata;
        dcache_pkg::word_t exp_rdata;    // reads only
        int                exp_ar;       // running AR burst count after the op
        int                exp_aw;       // running AW burst count after the op
        dcache_pkg::addr_t exp_aw_addr;
    } op_t;

    logic                  clk;
    logic                  arst_n;
    dcache_pkg::cpu_req_t  cpu_req;
    dcache_pkg::cpu_resp_t cpu_resp;
    dcache_pkg::axi_addr_t m_ar;
    dcache_pkg::axi_addr_t m_aw;
    dcache_pkg::axi_data_t m_r;
    dcache_pkg::axi_data_t m_w;
    logic                  m_arready;
    logic                  m_awready;
    logic                  m_wready;
    int                    ar_count;
    int                    aw_count;
    int                    w_count;
    dcache_pkg::addr_t     last_ar_addr;
    dcache_pkg::addr_t     last_aw_addr;

    op_t ops [$];
    int  errors;
    int  checks;
    int  cycles;
    int  limit;

    dcache_top u_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_req   (cpu_req),
        .cpu_resp  (cpu_resp),
        .m_ar      (m_ar),
        .m_arready (m_arready),
        .m_r       (m_r),
        .m_aw      (m_aw),
        .m_awready (m_awready),
        .m_w       (m_w),
        .m_wready  (m_wready)
    );

    axi_mem_model u_mem (
        .clk          (clk),
        .m_ar         (m_ar),
        .m_arready    (m_arready),
        .m_r          (m_r),
        .m_aw         (m_aw),
        .m_awready    (m_awready),
        .m_w          (m_w),
        .m_wready     (m_wready),
        .ar_count     (ar_count),
        .aw_count     (aw_count),
        .w_count      (w_count),
        .last_ar_addr (last_ar_addr),
        .last_aw_addr (last_aw_addr)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_word(input string name, input dcache_pkg::word_t got,
                              input dcache_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input dcache_pkg::addr_t got,
                              input dcache_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAIL %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic void add_op(input logic write, input dcache_pkg::addr_t addr,
                                   input dcache_pkg::strb_t wstrb,
                                   input dcache_pkg::word_t wdata,
                                   input dcache_pkg::word_t exp_rdata,
                                   input int exp_ar, input int exp_aw,
                                   input dcache_pkg::addr_t exp_aw_addr);
        op_t op;
        op.write       = write;
        op.addr        = addr;
        op.wstrb       = wstrb;
        op.wdata       = wdata;
        op.exp_rdata   = exp_rdata;
        op.exp_ar      = exp_ar;
        op.exp_aw      = exp_aw;
        op.exp_aw_addr = exp_aw_addr;
        ops.push_back(op);
    endfunction

    // lines 0x1040..0x9040 all map to set 1, memory word at A starts as A ^ c0de0000
    function automatic void build_table();
        add_op(1'b0, 32'h0000_1044, 4'h0, 32'h0,         32'hc0de_1044, 1, 0, 32'h0);
        add_op(1'b0, 32'h0000_1048, 4'h0, 32'h0,         32'hc0de_1048, 1, 0, 32'h0);
        add_op(1'b1, 32'h0000_1044, 4'h5, 32'haabb_ccdd, 32'h0,         1, 0, 32'h0);
        add_op(1'b0, 32'h0000_1044, 4'h0, 32'h0,         32'hc0bb_10dd, 1, 0, 32'h0);
        add_op(1'b1, 32'h0000_107c, 4'hf, 32'h1234_5678, 32'h0,         1, 0, 32'h0);
        add_op(1'b0, 32'h0000_2040, 4'h0, 32'h0,         32'hc0de_2040, 2, 0, 32'h0);
        add_op(1'b0, 32'h0000_3040, 4'h0, 32'h0,         32'hc0de_3040, 3, 0, 32'h0);
        add_op(1'b0, 32'h0000_4040, 4'h0, 32'h0,         32'hc0de_4040, 4, 0, 32'h0);
        add_op(1'b0, 32'h0000_5040, 4'h0, 32'h0,         32'hc0de_5040, 5, 1, 32'h0000_1040);
        add_op(1'b0, 32'h0000_1044, 4'h0, 32'h0,         32'hc0bb_10dd, 6, 1, 32'h0);
        add_op(1'b0, 32'h0000_107c, 4'h0, 32'h0,         32'h1234_5678, 6, 1, 32'h0);
        add_op(1'b1, 32'h0000_5048, 4'h8, 32'h9900_0000, 32'h0,         6, 1, 32'h0);
        add_op(1'b0, 32'h0000_5048, 4'h0, 32'h0,         32'h99de_5048, 6, 1, 32'h0);
        add_op(1'b0, 32'h0000_0080, 4'h0, 32'h0,         32'hc0de_0080, 7, 1, 32'h0);
        add_op(1'b0, 32'h0000_6040, 4'h0, 32'h0,         32'hc0de_6040, 8, 1, 32'h0);
        add_op(1'b0, 32'h0000_7040, 4'h0, 32'h0,         32'hc0de_7040, 9, 1, 32'h0);
        add_op(1'b0, 32'h0000_8040, 4'h0, 32'h0,         32'hc0de_8040, 10, 2, 32'h0000_5040);
        add_op(1'b0, 32'h0000_5048, 4'h0, 32'h0,         32'h99de_5048, 11, 2, 32'h0);
        add_op(1'b1, 32'h0000_9044, 4'h3, 32'h0000_beef, 32'h0,         12, 2, 32'h0);
        add_op(1'b0, 32'h0000_9044, 4'h0, 32'h0,         32'hc0de_beef, 12, 2, 32'h0);
    endfunction

    task automatic run_op(input int idx, input op_t op);
        int ar_before;
        int aw_before;
        ar_before     = ar_count;
        aw_before     = aw_count;
        cpu_req.valid = 1'b1;
        cpu_req.write = op.write;
        cpu_req.addr  = op.addr;
        cpu_req.wstrb = op.wstrb;
        cpu_req.wdata = op.wdata;
        @(negedge clk);
        while (!cpu_resp.ack) @(negedge clk);   // mid cycle, ack and rdata are settled
        if (!op.write) begin
            check_word($sformatf("op%0d rdata", idx), cpu_resp.rdata, op.exp_rdata);
        end
        @(posedge clk);
        #1;
        cpu_req = '0;
        check_count($sformatf("op%0d ar_count", idx), ar_count, op.exp_ar);
        check_count($sformatf("op%0d aw_count", idx), aw_count, op.exp_aw);
        check_count($sformatf("op%0d w_count", idx), w_count, 16 * op.exp_aw);
        if (ar_count != ar_before) begin
            check_addr($sformatf("op%0d ar_addr", idx), last_ar_addr,
                       op.addr & 32'hffff_ffc0);
        end
        if (aw_count != aw_before) begin
            check_addr($sformatf("op%0d aw_addr", idx), last_aw_addr, op.exp_aw_addr);
        end
    endtask

    initial begin
        errors  = 0;
        checks  = 0;
        limit   = 0;
        cpu_req = '0;
        arst_n  = 1'b0;
        build_table();
        limit = 400 * ops.size() + 100;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        for (int i = 0; i < ops.size(); i++) begin
            run_op(i, ops[i]);
        end
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("Test failures found");
        $finish;
    end

endmodule

// File: tb.f
verilog/dcache_pkg.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/axi_burst_master.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/axi_mem_model.sv
tests/dcache_checker.sv
tests/dcache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Test failures found
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator and run it, output in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG) || grep -q "%Error" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
